// File: src/hilbertCfg_cfg.svh
`ifndef HILBERT_CFG_SVH
`define HILBERT_CFG_SVH

// Build-time configuration of the Hilbert transformer.

// Number of filter taps.
// It must be odd so that the centre tap falls on a whole sample.
// The centre tap index is (HT_LENGTH - 1) / 2.
`define HT_LENGTH 27

// Width of the input samples and of the coefficients.
// Products and sums are carried at twice this width.
`define HT_DATA_WIDTH 18

`endif

// File: src/hilbertPkg.sv
`default_nettype none

`include "hilbertCfg_cfg.svh"

package hilbertPkg;

	// Signed real input sample.
	typedef logic signed [`HT_DATA_WIDTH - 1:0] sample_t;

	// Signed filter coefficient, same width as a sample.
	typedef logic signed [`HT_DATA_WIDTH - 1:0] coeff_t;

	// Signed output word.
	// Products and the tap sum live here and wrap on overflow.
	typedef logic signed [2 * `HT_DATA_WIDTH - 1:0] wide_t;

	// Real and quadrature halves of one output sample.
	// Both halves always leave the block together.
	typedef struct packed {
		wide_t re;
		wide_t im;
	} analytic_t;

	// One coefficient on its way from the ROM into the FIR.
	// The value only counts while valid is high.
	typedef struct packed {
		logic   valid;
		coeff_t value;
	} coeffBeat_t;

	// Controller states.
	typedef enum logic [1:0] {
		IDLE,
		LOAD_COEFF,
		RUN,
		STOP
	} htState_e;

endpackage

`default_nettype wire

// File: src/hilbertCoeffRom.sv
`timescale 1ns/1ns
`default_nettype none

`include "hilbertCfg_cfg.svh"

module hilbertCoeffRom import hilbertPkg::*; (
	input  logic       clock,
	input  logic       rstN,
	input  logic       loadCoeff,
	output coeffBeat_t coeffBeat,
	output logic       coeffDone
);

	localparam int  CENTRE = (`HT_LENGTH - 1) / 2;
	localparam int  IDX_W  = $clog2(`HT_LENGTH + 1);
	localparam real PI     = 3.14159265358979323846;

	// Ideal Hilbert response sampled at tap n.
	// Even offsets from the centre are zero, odd offsets follow 2/(pi*k).
	// The gain of 2^(W-2) keeps the largest tap well inside the signed range.
	function automatic coeff_t coeffAt(input int n);
		int  k;
		real v;
		k = n - CENTRE;
		if (k % 2 == 0) begin
			return '0;
		end
		v = (2.0 ** (`HT_DATA_WIDTH - 2)) * 2.0 / (PI * k);
		// The cast to int rounds to the nearest integer.
		return coeff_t'(int'(v));
	endfunction

	// Constant table, fixed at elaboration.
	coeff_t coeffTable [`HT_LENGTH];

	// Index of the next tap to send.
	logic [IDX_W - 1:0] tapIdx;

	for (genvar n = 0; n < `HT_LENGTH; n++) begin : genTable
		assign coeffTable[n] = coeffAt(n);
	end

	// The beat register doubles as the busy flag.
	// loadCoeff starts the walk with tap 0 on the very next edge.
	// After the last tap one idle cycle carries the coeffDone pulse.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			coeffBeat <= '0;
			coeffDone <= 1'b0;
			tapIdx    <= '0;
		end else begin
			coeffDone <= 1'b0;
			if (loadCoeff) begin
				coeffBeat.valid <= 1'b1;
				coeffBeat.value <= coeffTable[0];
				tapIdx          <= IDX_W'(1);
			end else if (coeffBeat.valid) begin
				if (tapIdx == IDX_W'(`HT_LENGTH)) begin
					// Every tap has gone out.
					coeffBeat <= '0;
					coeffDone <= 1'b1;
					tapIdx    <= '0;
				end else begin
					coeffBeat.value <= coeffTable[tapIdx];
					tapIdx          <= tapIdx + IDX_W'(1);
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: src/hilbertFir.sv
`timescale 1ns/1ns
`default_nettype none

`include "hilbertCfg_cfg.svh"

module hilbertFir import hilbertPkg::*; (
	input  logic       clock,
	input  logic       rstN,
	input  coeffBeat_t coeffBeat,
	input  logic       clear,
	input  logic       running,
	input  sample_t    dataIn,
	output wide_t      firOut
);

	// Coefficients, coeffReg[n] weighs the sample n cycles old.
	coeff_t coeffReg [`HT_LENGTH];

	// Sample history, dataReg[0] is the newest accepted sample.
	sample_t dataReg [`HT_LENGTH];

	// Unregistered sum of products.
	wide_t sumNext;

	// Coefficients enter at the top and move down one place per beat.
	// Tap 0 arrives first, so after HT_LENGTH beats it sits at index 0.
	// The values stay put between runs.
	always_ff @(posedge clock) begin
		if (coeffBeat.valid) begin
			for (int n = 0; n < `HT_LENGTH - 1; n++) begin
				coeffReg[n] <= coeffReg[n + 1];
			end
			coeffReg[`HT_LENGTH - 1] <= coeffBeat.value;
		end
	end

	// The sample history advances once per accepted sample.
	// clear wipes the older entries.
	// When clear and running coincide at the start of a run, the new sample
	// is still kept, so the first sample of a run sees an all-zero history.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int n = 0; n < `HT_LENGTH; n++) begin
				dataReg[n] <= '0;
			end
		end else begin
			if (running) begin
				dataReg[0] <= dataIn;
			end else if (clear) begin
				dataReg[0] <= '0;
			end
			for (int n = 1; n < `HT_LENGTH; n++) begin
				if (clear) begin
					dataReg[n] <= '0;
				end else if (running) begin
					dataReg[n] <= dataReg[n - 1];
				end
			end
		end
	end

	// Full-width products.
	// Both operands are sign extended before the multiply, and the sum wraps.
	always_comb begin
		sumNext = '0;
		for (int n = 0; n < `HT_LENGTH; n++) begin
			sumNext = sumNext + wide_t'(coeffReg[n]) * wide_t'(dataReg[n]);
		end
	end

	// Second pipeline stage of the filter.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			firOut <= '0;
		end else begin
			firOut <= sumNext;
		end
	end

endmodule

`default_nettype wire

// File: src/hilbertDelayLine.sv
`timescale 1ns/1ns
`default_nettype none

`include "hilbertCfg_cfg.svh"

module hilbertDelayLine import hilbertPkg::*; (
	input  logic    clock,
	input  logic    rstN,
	input  logic    clear,
	input  logic    running,
	input  sample_t dataIn,
	output wide_t   realOut
);

	localparam int CENTRE = (`HT_LENGTH - 1) / 2;

	// Stage 0 holds the newest sample and stage CENTRE the one CENTRE samples older.
	sample_t delayReg [CENTRE + 1];

	// Same shift and clear rules as the FIR history.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int n = 0; n <= CENTRE; n++) begin
				delayReg[n] <= '0;
			end
		end else begin
			if (running) begin
				delayReg[0] <= dataIn;
			end else if (clear) begin
				delayReg[0] <= '0;
			end
			for (int n = 1; n <= CENTRE; n++) begin
				if (clear) begin
					delayReg[n] <= '0;
				end else if (running) begin
					delayReg[n] <= delayReg[n - 1];
				end
			end
		end
	end

	// The output register stands in for the FIR sum register.
	// The shift by W-2 matches the gain built into the coefficients.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			realOut <= '0;
		end else begin
			realOut <= wide_t'(delayReg[CENTRE]) <<< (`HT_DATA_WIDTH - 2);
		end
	end

endmodule

`default_nettype wire

// File: src/hilbertControl.sv
`timescale 1ns/1ns
`default_nettype none

module hilbertControl import hilbertPkg::*; (
	input  logic      clock,
	input  logic      rstN,
	input  logic      enable,
	input  logic      stopDataIn,
	input  logic      coeffDone,
	input  wide_t     realOut,
	input  wide_t     firOut,
	output logic      loadCoeff,
	output logic      running,
	output logic      clear,
	output logic      outValid,
	output analytic_t dataOut
);

	htState_e state;

	// Tracks running through the two datapath stages.
	// outValid follows one more register behind.
	logic [1:0] validPipe;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state     <= IDLE;
			loadCoeff <= 1'b0;
			running   <= 1'b0;
			clear     <= 1'b0;
			outValid  <= 1'b0;
			validPipe <= '0;
			dataOut   <= '0;
		end else begin
			// Both strobes are single-cycle pulses.
			loadCoeff <= 1'b0;
			clear     <= 1'b0;
			case (state)
				IDLE: begin
					dataOut <= '0;
					if (enable) begin
						state     <= LOAD_COEFF;
						loadCoeff <= 1'b1;
					end
				end
				// The ROM is streaming taps into the FIR here.
				LOAD_COEFF: begin
					dataOut <= '0;
					if (coeffDone) begin
						state   <= RUN;
						running <= 1'b1;
						clear   <= 1'b1;
					end
				end
				RUN: begin
					if (stopDataIn) begin
						// Drop everything on the same edge and flush the history.
						state     <= STOP;
						running   <= 1'b0;
						clear     <= 1'b1;
						outValid  <= 1'b0;
						validPipe <= '0;
						dataOut   <= '0;
					end else begin
						validPipe <= {validPipe[0], 1'b1};
						outValid  <= validPipe[1];
						dataOut   <= '{re: realOut, im: firOut};
					end
				end
				// Wait for enable to drop before another load is allowed.
				STOP: begin
					dataOut <= '0;
					if (!enable) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/hilbertTransform.sv
`timescale 1ns/1ns
`default_nettype none

module hilbertTransform import hilbertPkg::*; (
	input  logic      clock,
	input  logic      rstN,
	input  logic      enable,
	input  logic      stopDataIn,
	input  sample_t   dataIn,
	output logic      running,
	output logic      outValid,
	output analytic_t dataOut
);

	// Coefficient path from the ROM into the FIR.
	coeffBeat_t coeffBeat;
	logic       coeffDone;
	logic       loadCoeff;

	// Clears both sample histories.
	logic clear;

	// Imaginary and real halves, both two cycles behind the input.
	wide_t firOut;
	wide_t realOut;

	// Holds the coefficient table and streams it out on request.
	hilbertCoeffRom rom0 (
		.clock     (clock),
		.rstN      (rstN),
		.loadCoeff (loadCoeff),
		.coeffBeat (coeffBeat),
		.coeffDone (coeffDone)
	);

	// Quadrature branch.
	hilbertFir fir0 (
		.clock     (clock),
		.rstN      (rstN),
		.coeffBeat (coeffBeat),
		.clear     (clear),
		.running   (running),
		.dataIn    (dataIn),
		.firOut    (firOut)
	);

	// Real branch.
	// It is delayed to the FIR group delay.
	hilbertDelayLine delay0 (
		.clock   (clock),
		.rstN    (rstN),
		.clear   (clear),
		.running (running),
		.dataIn  (dataIn),
		.realOut (realOut)
	);

	// Sequences the load and the run, and aligns the output pair.
	hilbertControl control0 (
		.clock      (clock),
		.rstN       (rstN),
		.enable     (enable),
		.stopDataIn (stopDataIn),
		.coeffDone  (coeffDone),
		.realOut    (realOut),
		.firOut     (firOut),
		.loadCoeff  (loadCoeff),
		.running    (running),
		.clear      (clear),
		.outValid   (outValid),
		.dataOut    (dataOut)
	);

endmodule

`default_nettype wire

// File: dv/hilbertTransformTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "hilbertCfg_cfg.svh"

module hilbertTransformTb import hilbertPkg::*; ();

	localparam int TAPS   = `HT_LENGTH;
	localparam int CENTRE = (`HT_LENGTH - 1) / 2;
	localparam int WIDTH  = `HT_DATA_WIDTH;
	localparam real PI    = 3.14159265358979323846;

	logic      clock;
	logic      rstN;
	logic      enable;
	logic      stopDataIn;
	sample_t   dataIn;
	logic      running;
	logic      outValid;
	analytic_t dataOut;

	// Reference coefficients and the samples accepted in the current run.
	coeff_t  coeffModel [TAPS];
	sample_t hist [$];

	logic [31:0] lfsrState = 32'h004a_8321;
	longint      limitNs;
	logic        limitReady = 1'b0;
	int          impulseLen;
	int          randomLen;
	int          restartLen;

	hilbertTransform dut0 (
		.clock      (clock),
		.rstN       (rstN),
		.enable     (enable),
		.stopDataIn (stopDataIn),
		.dataIn     (dataIn),
		.running    (running),
		.outValid   (outValid),
		.dataOut    (dataOut)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Prints the reason, then the fail message, and stops the run.
	task automatic failRun(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			failRun($sformatf("CHECK FAILED %s: expected %b actual %b", name, expected, actual));
		end
	endtask

	task automatic checkWide(input string name, input wide_t expected, input wide_t actual);
		if (actual !== expected) begin
			failRun($sformatf("CHECK FAILED %s: expected %0d actual %0d", name, expected, actual));
		end
	endtask

	task automatic checkAnalytic(input string name, input analytic_t expected,
			input analytic_t actual);
		if (actual !== expected) begin
			failRun($sformatf("CHECK FAILED %s: expected re %0d im %0d actual re %0d im %0d",
				name, expected.re, expected.im, actual.re, actual.im));
		end
	endtask

	// One step of the x^32 + x^22 + x^2 + x + 1 Fibonacci register.
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Each bit taken costs one LFSR step.
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrStep(lfsrState);
			bits = {bits[30:0], lfsrState[0]};
		end
		return bits;
	endfunction

	// Ideal Hilbert taps, scaled by 2^(W-2) and rounded half away from zero.
	function automatic void buildCoeffModel();
		int  k;
		real v;
		for (int n = 0; n < TAPS; n++) begin
			k = n - CENTRE;
			if (k % 2 == 0) begin
				coeffModel[n] = '0;
			end else begin
				v = (2.0 ** (WIDTH - 2)) * 2.0 / (PI * k);
				if (v >= 0.0) begin
					coeffModel[n] = coeff_t'($rtoi($floor(v + 0.5)));
				end else begin
					coeffModel[n] = coeff_t'(-$rtoi($floor(0.5 - v)));
				end
			end
		end
	endfunction

	// Output number idx of a run belongs to the sample accepted idx cycles after the start.
	// Samples before the run count as zero, and both halves wrap at wide_t.
	function automatic analytic_t expectedPair(input int idx);
		analytic_t result;
		longint    acc;
		longint    reVal;
		int        src;
		acc = 0;
		for (int n = 0; n < TAPS; n++) begin
			src = idx - n;
			if (src >= 0 && src < hist.size()) begin
				acc += longint'(coeffModel[n]) * longint'(hist[src]);
			end
		end
		src = idx - CENTRE;
		reVal = (src >= 0) ? longint'(hist[src]) * (longint'(1) << (WIDTH - 2)) : 0;
		result.re = wide_t'(reVal);
		result.im = wide_t'(acc);
		return result;
	endfunction

	// Checks that the block sits quiet for a number of cycles.
	task automatic checkIdle(input string name, input int cycles);
		for (int c = 0; c < cycles; c++) begin
			@(posedge clock);
			#1;
			checkBit({name, " running"}, 1'b0, running);
			checkBit({name, " outValid"}, 1'b0, outValid);
			checkAnalytic({name, " dataOut"}, '0, dataOut);
		end
	endtask

	// Loads the taps, streams length samples, stops and drops enable again.
	task automatic runStream(input string name, input int length, input bit impulse);
		int     idx;
		wide_t  reUnit;
		hist.delete();
		for (int j = 0; j < length; j++) begin
			if (impulse) begin
				hist.push_back((j == 0) ? sample_t'(1) : sample_t'(0));
			end else begin
				hist.push_back(sample_t'(randomBits(WIDTH)));
			end
		end
		enable = 1'b1;
		// The load takes a fixed number of cycles from the enable edge.
		for (int c = 1; c <= TAPS + 3; c++) begin
			@(posedge clock);
			#1;
			checkBit({name, " load running"}, logic'(c == TAPS + 3), running);
			checkBit({name, " load outValid"}, 1'b0, outValid);
		end
		for (int j = 0; j <= length; j++) begin
			stopDataIn = (j == length);
			dataIn     = (j < length) ? hist[j] : sample_t'(0);
			@(posedge clock);
			#1;
			if (j < length) begin
				checkBit({name, " running"}, 1'b1, running);
				checkBit({name, " outValid"}, logic'(j >= 2), outValid);
				if (j >= 2) begin
					idx = j - 2;
					if (impulse) begin
						// The impulse response is the tap table itself.
						reUnit = (idx == CENTRE) ? wide_t'(longint'(1) << (WIDTH - 2)) : '0;
						checkWide({name, " im"}, (idx < TAPS) ? wide_t'(coeffModel[idx]) : '0,
							dataOut.im);
						checkWide({name, " re"}, reUnit, dataOut.re);
					end else begin
						checkAnalytic({name, " pair"}, expectedPair(idx), dataOut);
					end
				end
			end else begin
				// The stop edge drops everything at once.
				checkBit({name, " stop running"}, 1'b0, running);
				checkBit({name, " stop outValid"}, 1'b0, outValid);
				checkAnalytic({name, " stop dataOut"}, '0, dataOut);
			end
		end
		stopDataIn = 1'b0;
		enable     = 1'b0;
		dataIn     = '0;
		checkIdle({name, " after stop"}, 4);
	endtask

	initial begin
		wait (limitReady);
		#(limitNs);
		failRun("Timeout: the runs did not finish in the expected time.");
	end

	initial begin
		rstN       = 1'b0;
		enable     = 1'b0;
		stopDataIn = 1'b0;
		dataIn     = '0;
		buildCoeffModel();
		impulseLen = TAPS + 4;
		randomLen  = 200;
		restartLen = 40 + int'(randomBits(6));
		limitNs    = longint'(impulseLen + randomLen + restartLen + 3 * (TAPS + 20)) * 10 * 2;
		limitReady = 1'b1;
		repeat (16) @(posedge clock);
		#1;
		rstN = 1'b1;
		checkIdle("after reset", 8);
		runStream("impulse", impulseLen, 1'b1);
		runStream("random stream", randomLen, 1'b0);
		runStream("restart", restartLen, 1'b0);
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: hilbertTransform.f
+incdir+src
src/hilbertPkg.sv
src/hilbertCoeffRom.sv
src/hilbertFir.sv
src/hilbertDelayLine.sv
src/hilbertControl.sv
src/hilbertTransform.sv
dv/hilbertTransformTb.sv

// File: run.sh
#!/bin/sh
# Builds and runs the Hilbert transformer testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -j 0 --top-module hilbertTransformTb \
	-f hilbertTransform.f -Mdir obj_dir -o hilbertTransformSim; then
	echo "Verilator build failed."
	exit 1
fi

./obj_dir/hilbertTransformSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG" || exit 1
if [ "$simStatus" -ne 0 ]; then
	echo "Simulation exited with status $simStatus."
	exit 1
fi

if grep -q -x 'All tests passed!' "$LOG"; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
